/* project.f */
+incdir+tb
src/det_pkg.sv
src/det_term_table.sv
src/det_mul_pipe.sv
src/det_sequencer.sv
src/det_accumulator.sv
src/det_top.sv
tb/det_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the det_top testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module det_tb -f project.f -o det_tb_sim \
    && ./obj_dir/det_tb_sim 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

# the log decides pass or fail
grep -q "Test failed" sim.log \
    && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation PASSED"; exit 0; }

/* tb/det_tb_tasks.svh */
`ifndef DET_TB_TASKS_SVH
`define DET_TB_TASKS_SVH

// low ELEM_W bits of a full product
function automatic det_pkg::elem_t mul_low(input det_pkg::elem_t a, input det_pkg::elem_t b);
    logic [2*det_pkg::ELEM_W-1:0] full;
    full = {{det_pkg::ELEM_W{1'b0}}, a} * {{det_pkg::ELEM_W{1'b0}}, b};
    return full[det_pkg::ELEM_W-1:0];
endfunction

// XOR of all permutation products, no sign
function automatic det_pkg::elem_t ref_det(input det_pkg::mat_t m, input det_pkg::size_t s);
    det_pkg::elem_t acc;
    acc = '0;
    if (s == det_pkg::size_t'(2)) begin
        acc = mul_low(m[0][0], m[1][1]) ^ mul_low(m[0][1], m[1][0]);
    end else if (s == det_pkg::size_t'(3)) begin
        // two-factor partial truncated before the third factor
        acc = mul_low(mul_low(m[0][0], m[1][1]), m[2][2])
            ^ mul_low(mul_low(m[0][1], m[1][2]), m[2][0])
            ^ mul_low(mul_low(m[0][2], m[1][0]), m[2][1])
            ^ mul_low(mul_low(m[0][2], m[1][1]), m[2][0])
            ^ mul_low(mul_low(m[0][1], m[1][0]), m[2][2])
            ^ mul_low(mul_low(m[0][0], m[1][2]), m[2][1]);
    end
    return acc;
endfunction

// row-major arguments, m[2][2] ends up in the top bits
function automatic det_pkg::mat_t make_mat3(
    input det_pkg::elem_t a00, input det_pkg::elem_t a01, input det_pkg::elem_t a02,
    input det_pkg::elem_t a10, input det_pkg::elem_t a11, input det_pkg::elem_t a12,
    input det_pkg::elem_t a20, input det_pkg::elem_t a21, input det_pkg::elem_t a22);
    return {a22, a21, a20, a12, a11, a10, a02, a01, a00};
endfunction

// 2x2 in the top left corner
function automatic det_pkg::mat_t make_mat2(
    input det_pkg::elem_t a00, input det_pkg::elem_t a01,
    input det_pkg::elem_t a10, input det_pkg::elem_t a11);
    return make_mat3(a00, a01, FILL, a10, a11, FILL, FILL, FILL, FILL);
endfunction

// near_top gives values just below 2^51
function automatic det_pkg::elem_t rand_elem(input bit near_top);
    logic [63:0] raw;
    det_pkg::elem_t e;
    raw = {$random(seed), $random(seed)};
    if (near_top) begin
        e = ~{{(det_pkg::ELEM_W-8){1'b0}}, raw[7:0]};
    end else begin
        e = raw[det_pkg::ELEM_W-1:0];
    end
    return e;
endfunction

// mix of plain and near-top elements, pattern shifts with k
function automatic det_pkg::mat_t rand_mat(input int k);
    det_pkg::mat_t m;
    for (int r = 0; r < det_pkg::MAT_DIM; r++) begin
        for (int c = 0; c < det_pkg::MAT_DIM; c++) begin
            m[r][c] = rand_elem(((k + r + c) % 4) == 0);
        end
    end
    return m;
endfunction

task automatic check_value(input string name, input det_pkg::elem_t expected,
                           input det_pkg::elem_t actual);
    checks++;
    value_a: assert (actual === expected) else begin
        $display("Mismatch in %s: expected %h, got %h", name, expected, actual);
        mismatch_errors++;
    end
endtask

// one four-phase request, called on a falling edge
task automatic run_request(input string name, input det_pkg::mat_t m,
                           input det_pkg::size_t s, input int hold_cycles,
                           output det_pkg::elem_t res, output int cycles);
    cycles = 0;
    checks++;
    idle_ack_a: assert (!ack) else begin
        $display("ack was already high before req rose in %s", name);
        handshake_errors++;
    end
    matrix = m;
    size = s;
    req = 1'b1;
    // latency varies with size, ack marks the end
    while (!ack && cycles < ACK_LIMIT) begin
        @(negedge clk);
        cycles++;
    end
    checks++;
    ack_rise_a: assert (ack) else begin
        $display("ack did not rise within %0d cycles in %s", ACK_LIMIT, name);
        handshake_errors++;
    end
    res = result;
    // ack has to stay up as long as req does
    for (int i = 0; i < hold_cycles; i++) begin
        @(negedge clk);
        checks++;
        ack_hold_a: assert (ack) else begin
            $display("ack fell while req was still high in %s", name);
            handshake_errors++;
        end
    end
    req = 1'b0;
    @(negedge clk);
    checks++;
    ack_fall_a: assert (!ack) else begin
        $display("ack was still high one cycle after req fell in %s", name);
        handshake_errors++;
    end
endtask

task automatic size2_known_matrices();
    det_pkg::elem_t res;
    int cyc;
    // 33 ^ 35
    run_request("size2 small a", make_mat2(3, 5, 7, 11), 2, 0, res, cyc);
    check_value("size2 small a", 51'd2, res);
    run_request("size2 diagonal", make_mat2(2, 0, 0, 9), 2, 0, res, cyc);
    check_value("size2 diagonal", 51'd18, res);
    // 36 ^ 16
    run_request("size2 small b", make_mat2(6, 4, 4, 6), 2, 0, res, cyc);
    check_value("size2 small b", 51'd52, res);
    // (2^51-1)^2 is 1 mod 2^51, both terms cancel
    run_request("size2 all ones", make_mat2('1, '1, '1, '1), 2, 0, res, cyc);
    check_value("size2 all ones", 51'd0, res);
endtask

task automatic size3_known_matrices();
    det_pkg::elem_t res;
    int cyc;
    det_pkg::mat_t m;
    run_request("size3 identity", make_mat3(1, 0, 0, 0, 1, 0, 0, 0, 1), 3, 0, res, cyc);
    check_value("size3 identity", 51'd1, res);
    // every term takes one factor from row 1
    m = rand_mat(1);
    m[1] = '0;
    run_request("size3 zero row", m, 3, 0, res, cyc);
    check_value("size3 zero row", 51'd0, res);
    // 50 ^ 84 ^ 96 ^ 105 ^ 80 ^ 48
    run_request("size3 hand picked", make_mat3(1, 2, 3, 4, 5, 6, 7, 8, 10), 3, 0, res, cyc);
    check_value("size3 hand picked", 51'd15, res);
endtask

task automatic random_matrices();
    det_pkg::elem_t res;
    det_pkg::mat_t m;
    det_pkg::size_t s;
    int cyc;
    string name;
    // twenty of size 3, then ten of size 2
    for (int k = 0; k < 30; k++) begin
        s = (k < 20) ? det_pkg::size_t'(3) : det_pkg::size_t'(2);
        m = rand_mat(k);
        name = $sformatf("random %0d size %0d", k, s);
        run_request(name, m, s, 0, res, cyc);
        check_value(name, ref_det(m, s), res);
    end
endtask

// zero terms, result 0 after two cycles
task automatic one_unsupported(input det_pkg::size_t s);
    det_pkg::elem_t res;
    int cyc;
    string name;
    name = $sformatf("unsupported size %0d", s);
    run_request(name, make_mat3(1, 2, 3, 4, 5, 6, 7, 8, 9), s, 0, res, cyc);
    check_value(name, 51'd0, res);
    checks++;
    latency_a: assert (cyc == 2) else begin
        $display("Mismatch in %s: expected 2 cycles to ack, got %0d", name, cyc);
        mismatch_errors++;
    end
endtask

task automatic unsupported_sizes();
    one_unsupported(0);
    one_unsupported(1);
    one_unsupported(4);
    one_unsupported(31);
endtask

task automatic ack_hold();
    det_pkg::elem_t res;
    det_pkg::mat_t m;
    int cyc;
    m = rand_mat(2);
    // req stays up 20 cycles past ack
    run_request("ack hold", m, 3, 20, res, cyc);
    check_value("ack hold", ref_det(m, 3), res);
endtask

task automatic back_to_back();
    det_pkg::elem_t res;
    det_pkg::mat_t m1;
    det_pkg::mat_t m2;
    int cyc;
    m1 = rand_mat(0);
    m2 = rand_mat(3);
    // second req rises on the edge where ack was seen low
    run_request("back to back first", m1, 3, 0, res, cyc);
    check_value("back to back first", ref_det(m1, 3), res);
    run_request("back to back second", m2, 3, 0, res, cyc);
    check_value("back to back second", ref_det(m2, 3), res);
endtask

`endif

/* tb/det_tb.sv */
`timescale 1ns/1ps

module det_tb;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    // requests sent by the whole sequence below
    localparam int NUM_REQUESTS = 44;
    // budget per request for the watchdog
    localparam int CYCLES_PER_REQUEST = 64;
    // longest wait for ack before giving up
    localparam int ACK_LIMIT = 64;
    // filler for entries that a 2x2 request must ignore
    localparam det_pkg::elem_t FILL = 51'h5_5a5a_a5a5_c3c3;

    logic           clk;
    logic           rst;
    logic           req;
    det_pkg::mat_t  matrix;
    det_pkg::size_t size;
    logic           ack;
    det_pkg::elem_t result;

    // random stream state
    int seed;
    // error bookkeeping
    int checks;
    int mismatch_errors;
    int handshake_errors;

    det_top det_top_i (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .matrix (matrix),
        .size   (size),
        .ack    (ack),
        .result (result)
    );

    // 100 ns clock
    always #(CLK_PERIOD / 2) clk = ~clk;

    `include "det_tb_tasks.svh"

    // one closing line with all counts
    task automatic report_counts();
        $display("checks: %0d, mismatches: %0d, handshake errors: %0d",
                 checks, mismatch_errors, handshake_errors);
    endtask

    // ack must be low once reset is released
    task automatic check_reset_ack();
        checks++;
        reset_ack_a: assert (!ack) else begin
            $display("ack is high right after reset");
            handshake_errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        matrix = '0;
        size = '0;
        seed = 32'h4f6888f6;
        checks = 0;
        mismatch_errors = 0;
        handshake_errors = 0;

        // reset held for ten cycles, released on a falling edge
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_ack();

        // every task below starts and ends on a falling edge
        size2_known_matrices();
        size3_known_matrices();
        random_matrices();
        unsupported_sizes();
        ack_hold();
        back_to_back();

        report_counts();
        if (mismatch_errors == 0 && handshake_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // ends a run that hangs on a lost ack
    initial begin : watchdog
        #(NUM_REQUESTS * CYCLES_PER_REQUEST * CLK_PERIOD);
        $display("timeout: the test sequence did not finish within %0d cycles",
                 NUM_REQUESTS * CYCLES_PER_REQUEST);
        report_counts();
        $display("Test failed");
        $finish;
    end

endmodule

/* src/det_top.sv */
`timescale 1ns/1ps

module det_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           req,
    input  det_pkg::mat_t  matrix,
    input  det_pkg::size_t size,
    output logic           ack,
    output det_pkg::elem_t result
);

    // decode
    det_pkg::term_t    issue_term;
    det_pkg::term_t    fb_term;
    det_pkg::elem_t    issue_a;
    det_pkg::elem_t    issue_b;
    det_pkg::elem_t    fb_c;
    logic              issue_n3;
    // execute
    logic              mul_valid;
    det_pkg::mul_req_t mul_req;
    logic              rsp_valid;
    det_pkg::mul_rsp_t mul_rsp;
    // result
    logic              clear;
    logic              all_done;

    det_term_table det_term_table_i (
        .matrix     (matrix),
        .size       (size),
        .issue_term (issue_term),
        .fb_term    (fb_term),
        .issue_a    (issue_a),
        .issue_b    (issue_b),
        .fb_c       (fb_c),
        .issue_n3   (issue_n3)
    );

    det_sequencer det_sequencer_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .size       (size),
        .issue_a    (issue_a),
        .issue_b    (issue_b),
        .fb_c       (fb_c),
        .issue_n3   (issue_n3),
        .rsp_valid  (rsp_valid),
        .mul_rsp    (mul_rsp),
        .all_done   (all_done),
        .ack        (ack),
        .issue_term (issue_term),
        .fb_term    (fb_term),
        .mul_valid  (mul_valid),
        .mul_req    (mul_req),
        .clear      (clear)
    );

    det_mul_pipe det_mul_pipe_i (
        .clk       (clk),
        .rst       (rst),
        .mul_valid (mul_valid),
        .mul_req   (mul_req),
        .rsp_valid (rsp_valid),
        .mul_rsp   (mul_rsp)
    );

    // watches the same response bus as the sequencer
    det_accumulator det_accumulator_i (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .size      (size),
        .rsp_valid (rsp_valid),
        .mul_rsp   (mul_rsp),
        .all_done  (all_done),
        .result    (result)
    );

endmodule

/* src/det_accumulator.sv */
`timescale 1ns/1ps

module det_accumulator (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  det_pkg::size_t    size,
    input  logic              rsp_valid,
    input  det_pkg::mul_rsp_t mul_rsp,
    output logic              all_done,
    output det_pkg::elem_t    result
);

    det_pkg::term_t count;
    det_pkg::elem_t sum;
    // finished term from the multiplier
    logic           take;

    assign take = rsp_valid && mul_rsp.tag.is_final;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            all_done <= 1'b0;
        end else if (clear) begin
            count <= '0;
            all_done <= 1'b0;
        end else begin
            if (take) begin
                count <= count + 1'b1;
            end
            // one cycle behind the count
            all_done <= (count == det_pkg::term_count(size));
        end
    end

    // unsigned XOR of all terms
    always_ff @(posedge clk) begin
        if (clear) begin
            sum <= '0;
        end else if (take) begin
            sum <= sum ^ mul_rsp.prod;
        end
    end

    // held until the next clear
    assign result = sum;

    // more final products than terms means a lost or doubled tag
    count_max_a: assert property (@(posedge clk) disable iff (rst)
        count <= det_pkg::term_t'(det_pkg::MAX_TERMS));

endmodule

/* src/det_sequencer.sv */
`timescale 1ns/1ps

module det_sequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  det_pkg::size_t    size,
    input  det_pkg::elem_t    issue_a,
    input  det_pkg::elem_t    issue_b,
    input  det_pkg::elem_t    fb_c,
    input  logic              issue_n3,
    input  logic              rsp_valid,
    input  det_pkg::mul_rsp_t mul_rsp,
    input  logic              all_done,
    output logic              ack,
    output det_pkg::term_t    issue_term,
    output det_pkg::term_t    fb_term,
    output logic              mul_valid,
    output det_pkg::mul_req_t mul_req,
    output logic              clear
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_hold
    } state_t;

    state_t         state;
    det_pkg::term_t total;
    // terms still to be issued
    logic           issue_busy;
    logic           issue_last;
    logic           issue_fire;
    // partial product back from the multiplier, needs row 2
    logic           fb_pending;

    assign total = det_pkg::term_count(size);
    assign fb_term = mul_rsp.tag.term;
    assign fb_pending = rsp_valid && !mul_rsp.tag.is_final;
    // feedback owns the multiplier slot, new issue waits
    assign issue_fire = (state == st_run) && issue_busy && !fb_pending;
    assign issue_last = (issue_term == total - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            ack <= 1'b0;
            clear <= 1'b0;
            issue_busy <= 1'b0;
            issue_term <= '0;
            mul_valid <= 1'b0;
        end else begin
            clear <= 1'b0;
            mul_valid <= fb_pending || issue_fire;
            // index stops on the last term
            if (issue_fire) begin
                if (issue_last) begin
                    issue_busy <= 1'b0;
                end else begin
                    issue_term <= issue_term + 1'b1;
                end
            end
            case (state)
                st_idle: begin
                    if (req && !ack) begin
                        state <= st_run;
                        clear <= 1'b1;
                        issue_busy <= (total != '0);
                        issue_term <= '0;
                    end
                end
                st_run: begin
                    // all_done is stale while clear is still high
                    // no terms at all, result is the cleared sum
                    if ((clear && total == '0) || (!clear && all_done)) begin
                        ack <= 1'b1;
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    // four-phase, wait for req to drop
                    if (!req) begin
                        ack <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // request payload, feedback or a fresh term
    always_ff @(posedge clk) begin
        if (fb_pending) begin
            mul_req.a <= mul_rsp.prod;
            mul_req.b <= fb_c;
            mul_req.tag.term <= mul_rsp.tag.term;
            mul_req.tag.is_final <= 1'b1;
        end else begin
            mul_req.a <= issue_a;
            mul_req.b <= issue_b;
            mul_req.tag.term <= issue_term;
            // two-factor terms finish in one pass
            mul_req.tag.is_final <= !issue_n3;
        end
    end

    // partials only come back while running, and only for a term already issued
    fb_slot_a: assert property (@(posedge clk) disable iff (rst)
        fb_pending |-> (state == st_run)
            && (!issue_busy || mul_rsp.tag.term < issue_term));

endmodule

/* src/det_mul_pipe.sv */
`timescale 1ns/1ps

module det_mul_pipe (
    input  logic              clk,
    input  logic              rst,
    input  logic              mul_valid,
    input  det_pkg::mul_req_t mul_req,
    output logic              rsp_valid,
    output det_pkg::mul_rsp_t mul_rsp
);

    // valid and tag shift alongside the data
    logic [det_pkg::MUL_LATENCY-1:0] vld;
    det_pkg::mul_tag_t               tag_q [det_pkg::MUL_LATENCY];

    // stage 1 operands
    det_pkg::elem_t op_a;
    det_pkg::elem_t op_b;
    // stage 2 partial products, low half and shifted high half of b
    det_pkg::elem_t pp_lo;
    logic [det_pkg::ELEM_W-det_pkg::MUL_SPLIT-1:0] pp_hi;
    // stage 3 sum, then plain delay up to the output
    det_pkg::elem_t prod_q [det_pkg::MUL_LATENCY-2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[det_pkg::MUL_LATENCY-2:0], mul_valid};
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= mul_req.tag;
        for (int i = 1; i < det_pkg::MUL_LATENCY; i++) begin
            tag_q[i] <= tag_q[i-1];
        end
        op_a <= mul_req.a;
        op_b <= mul_req.b;
        // only the low ELEM_W product bits are kept
        pp_lo <= op_a * op_b[det_pkg::MUL_SPLIT-1:0];
        // high half lands above MUL_SPLIT, so its top bits fall off
        pp_hi <= op_a[det_pkg::ELEM_W-det_pkg::MUL_SPLIT-1:0]
               * op_b[det_pkg::ELEM_W-1:det_pkg::MUL_SPLIT];
        prod_q[0] <= pp_lo + {pp_hi, {det_pkg::MUL_SPLIT{1'b0}}};
        for (int i = 1; i < det_pkg::MUL_LATENCY - 2; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign rsp_valid = vld[det_pkg::MUL_LATENCY-1];
    assign mul_rsp.prod = prod_q[det_pkg::MUL_LATENCY-3];
    assign mul_rsp.tag = tag_q[det_pkg::MUL_LATENCY-1];

    // an unknown valid would corrupt every stage behind it
    valid_known_a: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(mul_valid));

endmodule

/* src/det_term_table.sv */
`timescale 1ns/1ps

module det_term_table (
    input  det_pkg::mat_t  matrix,
    input  det_pkg::size_t size,
    input  det_pkg::term_t issue_term,
    input  det_pkg::term_t fb_term,
    output det_pkg::elem_t issue_a,
    output det_pkg::elem_t issue_b,
    output det_pkg::elem_t fb_c,
    output logic           issue_n3
);

    // column picked in rows 0, 1, 2 for each 3x3 term
    // packed as {row0, row1, row2}
    function automatic logic [5:0] perm3(input det_pkg::term_t term);
        logic [5:0] cols;
        case (term)
            3'd0:    cols = {2'd0, 2'd1, 2'd2};
            3'd1:    cols = {2'd1, 2'd2, 2'd0};
            3'd2:    cols = {2'd2, 2'd0, 2'd1};
            3'd3:    cols = {2'd2, 2'd1, 2'd0};
            3'd4:    cols = {2'd1, 2'd0, 2'd2};
            3'd5:    cols = {2'd0, 2'd2, 2'd1};
            default: cols = '0;
        endcase
        return cols;
    endfunction

    // 2x2 terms: main diagonal, then anti-diagonal
    function automatic logic [3:0] perm2(input det_pkg::term_t term);
        logic [3:0] cols;
        case (term)
            3'd0:    cols = {2'd0, 2'd1};
            3'd1:    cols = {2'd1, 2'd0};
            default: cols = '0;
        endcase
        return cols;
    endfunction

    logic [5:0] cols_3;
    logic [3:0] cols_2;
    logic [5:0] fb_cols;

    assign cols_3 = perm3(issue_term);
    assign cols_2 = perm2(issue_term);
    assign fb_cols = perm3(fb_term);

    // first two factors come from rows 0 and 1
    always_comb begin
        issue_a = '0;
        issue_b = '0;
        issue_n3 = 1'b0;
        case (size)
            det_pkg::size_t'(2): begin
                issue_a = matrix[0][cols_2[3:2]];
                issue_b = matrix[1][cols_2[1:0]];
            end
            det_pkg::size_t'(3): begin
                issue_a = matrix[0][cols_3[5:4]];
                issue_b = matrix[1][cols_3[3:2]];
                // partial goes round again for row 2
                issue_n3 = 1'b1;
            end
            default: begin
                // unsupported size, nothing is issued
                issue_n3 = 1'b0;
            end
        endcase
    end

    // third factor, row 2, only for 3x3 feedback
    assign fb_c = matrix[2][fb_cols[1:0]];

    // sequencer must stop its index on the last term
    always_comb begin
        if (!$isunknown(issue_term)) begin
            term_range_a: assert final (issue_term < det_pkg::term_t'(det_pkg::MAX_TERMS));
        end
    end

endmodule

/* src/det_pkg.sv */
package det_pkg;

    // element and result width
    localparam int ELEM_W = 51;
    // largest matrix dimension, 3x3
    localparam int MAT_DIM = 3;
    // width of the size input
    localparam int SIZE_W = 5;
    // multiplier pipeline depth, at least 3
    localparam int MUL_LATENCY = 4;
    // six permutation terms for size 3
    localparam int MAX_TERMS = 6;
    localparam int TERM_W = 3;
    // multiplier splits operand b at this bit
    localparam int MUL_SPLIT = 26;

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [SIZE_W-1:0] size_t;
    typedef logic [TERM_W-1:0] term_t;

    // matrix[row][col]
    typedef elem_t [MAT_DIM-1:0][MAT_DIM-1:0] mat_t;

    // travels with every product
    typedef struct packed {
        term_t term;
        // set when this product completes its term
        logic  is_final;
    } mul_tag_t;

    typedef struct packed {
        elem_t    a;
        elem_t    b;
        mul_tag_t tag;
    } mul_req_t;

    typedef struct packed {
        elem_t    prod;
        mul_tag_t tag;
    } mul_rsp_t;

    // number of permutation terms for a size
    // sizes other than 2 and 3 have none
    function automatic term_t term_count(input size_t size);
        term_t n;
        case (size)
            size_t'(2): n = term_t'(2);
            size_t'(3): n = term_t'(MAX_TERMS);
            default:    n = '0;
        endcase
        return n;
    endfunction

endpackage
